// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_motor_bridge
FILELIST := project.f
OBJ_DIR  := obj_dir

BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
source/motor_bus_pkg.sv
source/spi_frame_pkg.sv
source/spi_byte_slave.sv
source/frame_sequencer.sv
source/reg_decoder.sv
source/motor_channel.sv
source/readback_mux.sv
source/motor_bridge_top.sv
sim/motor_bridge_assert.sv
sim/tb_motor_bridge.sv

// File: sim/motor_bridge_assert.sv
// bus protocol assertions
`timescale 1ns/1ps
`default_nettype none

module motor_bridge_assert (
  input logic                                 wCLK24,
  input logic                                 reset_i,
  input logic                                 frame_n_i,
  input logic                                 busy_i,
  input logic [motor_bus_pkg::BUS_ADDR_W-1:0] bus_addr_i,
  input logic                                 bus_write_i,
  input logic                                 bus_read_i,
  input logic                                 addr_bad_i
);

  a_no_write_with_read: assert property (@(posedge wCLK24) disable iff (reset_i)
    !(bus_write_i && bus_read_i))
    else $error("bus write and bus read are high together");

  a_bus_only_when_busy: assert property (@(posedge wCLK24) disable iff (reset_i)
    (bus_write_i || bus_read_i) |-> busy_i)
    else $error("bus access outside the busy window");

  a_write_addr_valid: assert property (@(posedge wCLK24) disable iff (reset_i)
    bus_write_i |-> !addr_bad_i)
    else $error("write to an invalid address");

  a_frame_not_while_busy: assert property (@(posedge wCLK24) disable iff (reset_i)
    $fell(frame_n_i) |-> !busy_i)
    else $error("frame strobe fell while the sequencer was busy");

endmodule

bind motor_bridge_top motor_bridge_assert i_motor_bridge_assert (
  .wCLK24      (wCLK24),
  .reset_i     (reset_i),
  .frame_n_i   (frame_n_i),
  .busy_i      (busy_o),
  .bus_addr_i  (bus_addr),
  .bus_write_i (bus_write),
  .bus_read_i  (bus_read),
  .addr_bad_i  (addr_bad)
);

`default_nettype wire

// File: sim/tb_motor_bridge.sv
// motor bridge testbench
`timescale 1ns/1ps
`default_nettype none

module tb_motor_bridge;
  import spi_frame_pkg::*;

  localparam int N_MOT        = RX_FRAME_BYTES / RX_BYTES_PER_MOTOR;
  localparam int HALF_SCK     = 8;
  localparam int BUSY_TIMEOUT = 1000;

  logic               wCLK24;
  logic               reset_i;
  logic               frame_n;
  logic               spi_sck;
  logic               spi_mosi;
  logic               spi_miso;
  logic               busy;
  logic signed [15:0] motor_pos [N_MOT];
  logic signed [15:0] motor_pwm [N_MOT];

  // host frames, model of the receive buffer, expected transmit image
  logic [7:0]  mosi_bytes [RX_FRAME_BYTES];
  logic [7:0]  miso_bytes [RX_FRAME_BYTES];
  logic [7:0]  rx_image   [RX_FRAME_BYTES];
  logic [7:0]  tx_expect  [TX_FRAME_BYTES];
  logic [31:0] lcg_state;
  longint      kept_pwm [N_MOT];

  motor_bridge_top i_motor_bridge_top (
    .wCLK24      (wCLK24),
    .reset_i     (reset_i),
    .frame_n_i   (frame_n),
    .spi_sck_i   (spi_sck),
    .spi_mosi_i  (spi_mosi),
    .motor_pos_i (motor_pos),
    .spi_miso_o  (spi_miso),
    .busy_o      (busy),
    .motor_pwm_o (motor_pwm)
  );

  initial begin
    wCLK24 = 1'b0;
    forever #10 wCLK24 = ~wCLK24;
  end

  // upper half of the lcg state as its low bits are weak
  function automatic logic [15:0] next_random16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  task automatic check_value(input string name, input longint expected, input longint actual);
    if (expected != actual) begin
      $display("FAILED %s expected %0d actual %0d", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // gain times error, arithmetic shift by 8, symmetric clamp
  function automatic longint model_pwm(input int m, input logic signed [15:0] pos);
    int                 base;
    logic [15:0]        kp;
    logic signed [31:0] sp;
    logic [15:0]        lim;
    longint             err;
    longint             ctrl;
    base = m * RX_BYTES_PER_MOTOR;
    kp   = {rx_image[base+1], rx_image[base]};
    sp   = {rx_image[base+5], rx_image[base+4], rx_image[base+3], rx_image[base+2]};
    lim  = {rx_image[base+7], rx_image[base+6]};
    err  = longint'(sp) - longint'(pos);
    ctrl = (longint'(kp) * err) >>> 8;
    if (ctrl > longint'(lim)) begin
      ctrl = longint'(lim);
    end else if (ctrl < -longint'(lim)) begin
      ctrl = -longint'(lim);
    end
    return ctrl;
  endfunction

  function automatic void put_motor_params(input int m, input logic [15:0] kp,
                                           input logic [31:0] sp, input logic [15:0] lim);
    int base;
    base = m * RX_BYTES_PER_MOTOR;
    mosi_bytes[base]   = kp[7:0];
    mosi_bytes[base+1] = kp[15:8];
    mosi_bytes[base+2] = sp[7:0];
    mosi_bytes[base+3] = sp[15:8];
    mosi_bytes[base+4] = sp[23:16];
    mosi_bytes[base+5] = sp[31:24];
    mosi_bytes[base+6] = lim[7:0];
    mosi_bytes[base+7] = lim[15:8];
  endfunction

  // small values keep most results out of saturation
  function automatic void fill_random_frame(input logic small_vals);
    logic [15:0] kp;
    logic [15:0] lo;
    logic [31:0] sp;
    logic [15:0] lim;
    for (int m = 0; m < N_MOT; m++) begin
      kp  = next_random16();
      lo  = next_random16();
      sp  = {next_random16(), lo};
      lim = next_random16() & 16'h7FFF;
      if (small_vals) begin
        kp = kp & 16'h01FF;
        sp = {{16{lo[15]}}, lo};
      end
      put_motor_params(m, kp, sp, lim);
    end
  endfunction

  function automatic void randomize_positions();
    for (int m = 0; m < N_MOT; m++) begin
      motor_pos[m] = next_random16();
    end
  endfunction

  // mode 0 host sampling MISO just before each rising SCK
  task automatic spi_transfer(input int n_bytes);
    frame_n = 1'b0;
    for (int i = 0; i < n_bytes; i++) begin
      for (int b = 7; b >= 0; b--) begin
        spi_mosi = mosi_bytes[i][b];
        repeat (HALF_SCK) @(negedge wCLK24);
        miso_bytes[i][b] = spi_miso;
        spi_sck = 1'b1;
        repeat (HALF_SCK) @(negedge wCLK24);
        spi_sck = 1'b0;
      end
    end
    repeat (HALF_SCK) @(negedge wCLK24);
    frame_n = 1'b1;
  endtask

  task automatic wait_busy(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (busy !== level) begin
      if (cycles == BUSY_TIMEOUT) begin
        $display("timeout while waiting for busy to %s", what);
        $display("CHECKS FAILED");
        $fatal(1, "busy did not change in time");
      end else begin
        cycles++;
        @(negedge wCLK24);
      end
    end
  endtask

  // status words as the read phase stores them low byte first
  function automatic void expect_readback();
    longint pwm;
    for (int m = 0; m < N_MOT; m++) begin
      pwm = model_pwm(m, motor_pos[m]);
      tx_expect[m*TX_BYTES_PER_MOTOR]   = motor_pos[m][7:0];
      tx_expect[m*TX_BYTES_PER_MOTOR+1] = motor_pos[m][15:8];
      tx_expect[m*TX_BYTES_PER_MOTOR+2] = pwm[7:0];
      tx_expect[m*TX_BYTES_PER_MOTOR+3] = pwm[15:8];
    end
  endfunction

  task automatic compare_pwm_outputs(input string name);
    for (int m = 0; m < N_MOT; m++) begin
      check_value($sformatf("%s pwm %0d", name, m), model_pwm(m, motor_pos[m]), motor_pwm[m]);
    end
  endtask

  task automatic send_frame(input int n_bytes, input string name);
    longint exp_byte;
    spi_transfer(n_bytes);
    for (int i = 0; i < n_bytes; i++) begin
      rx_image[i] = mosi_bytes[i];
    end
    wait_busy(1'b1, "rise");
    wait_busy(1'b0, "fall");
    // bytes past the transmit image shift out as zero
    for (int i = 0; i < n_bytes; i++) begin
      if (i < TX_FRAME_BYTES) begin
        exp_byte = tx_expect[i];
      end else begin
        exp_byte = 0;
      end
      check_value($sformatf("%s miso byte %0d", name, i), exp_byte, miso_bytes[i]);
    end
    expect_readback();
    repeat (2) @(negedge wCLK24);
    compare_pwm_outputs(name);
  endtask

  initial begin
    lcg_state  = 32'd88532;
    reset_i    = 1'b1;
    frame_n    = 1'b1;
    spi_sck    = 1'b0;
    spi_mosi   = 1'b0;
    for (int m = 0; m < N_MOT; m++) begin
      motor_pos[m] = '0;
      kept_pwm[m]  = 0;
    end
    for (int i = 0; i < RX_FRAME_BYTES; i++) begin
      mosi_bytes[i] = '0;
      miso_bytes[i] = '0;
      rx_image[i]   = '0;
    end
    for (int i = 0; i < TX_FRAME_BYTES; i++) begin
      tx_expect[i] = '0;
    end
    repeat (16) @(negedge wCLK24);
    reset_i = 1'b0;
    repeat (4) @(negedge wCLK24);

    check_value("reset busy", 0, busy);
    check_value("reset miso", 0, spi_miso);
    for (int m = 0; m < N_MOT; m++) begin
      check_value($sformatf("reset pwm %0d", m), 0, motor_pwm[m]);
    end

    // first frame also reads back the all-zero reset image
    for (int r = 0; r < 6; r++) begin
      randomize_positions();
      fill_random_frame(r[0]);
      send_frame(RX_FRAME_BYTES, $sformatf("random frame %0d", r));
      repeat (4) @(negedge wCLK24);
    end

    // only motor 0 bytes go out so the rest of the buffer stays stale
    for (int m = 1; m < N_MOT; m++) begin
      kept_pwm[m] = model_pwm(m, motor_pos[m]);
    end
    fill_random_frame(1'b1);
    send_frame(RX_BYTES_PER_MOTOR, "short frame");
    for (int m = 1; m < N_MOT; m++) begin
      check_value($sformatf("short frame kept pwm %0d", m), kept_pwm[m], motor_pwm[m]);
    end

    randomize_positions();
    repeat (4) @(negedge wCLK24);
    compare_pwm_outputs("position change");

    put_motor_params(0, 16'hFFFF, 32'h4000_0000, 16'd1234);
    put_motor_params(1, 16'hFFFF, 32'hC000_0000, 16'h7FFF);
    put_motor_params(2, 16'hFFFF, 32'h1000_0000, 16'h0000);
    put_motor_params(3, 16'h8000, 32'h8000_0000, 16'h0000);
    send_frame(RX_FRAME_BYTES, "saturation");
    check_value("saturation high", 1234, motor_pwm[0]);
    check_value("saturation low", -32767, motor_pwm[1]);
    check_value("zero limit 2", 0, motor_pwm[2]);
    check_value("zero limit 3", 0, motor_pwm[3]);
    repeat (4) @(negedge wCLK24);

    // reads back the saturated outputs
    randomize_positions();
    fill_random_frame(1'b0);
    send_frame(RX_FRAME_BYTES, "final frame");

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/frame_sequencer.sv
// frame sequencer
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
  input  logic                                 wCLK24,
  input  logic                                 reset_i,
  input  logic                                 frame_n_i,
  input  logic                                 rx_valid_i,
  input  logic [spi_frame_pkg::SPI_BYTE_W-1:0] rx_byte_i,
  output logic                                 tx_load_o,
  output logic [spi_frame_pkg::SPI_BYTE_W-1:0] tx_byte_o,
  output logic                                 busy_o,
  output logic [motor_bus_pkg::BUS_ADDR_W-1:0] bus_addr_o,
  output logic                                 bus_write_o,
  output logic                                 bus_read_o,
  output motor_bus_pkg::bus_wdata_u            bus_wdata_o,
  input  logic                                 bus_wait_i,
  input  logic [motor_bus_pkg::BUS_DATA_W-1:0] bus_rdata_i
);
  import motor_bus_pkg::*;
  import spi_frame_pkg::*;

  enum logic [2:0] {S_IDLE, S_RECV, S_WRITE, S_WRITE_WAIT, S_READ, S_READ_WAIT} state_q;

  logic [SPI_BYTE_W-1:0] rx_buf [RX_FRAME_BYTES];
  logic [SPI_BYTE_W-1:0] tx_buf [TX_FRAME_BYTES];
  logic [BYTE_CNT_W-1:0] byte_cnt_q;
  logic [1:0]            step_q;
  logic [MOT_W-1:0]      mot_q;
  logic                  last_mot;
  logic                  rx_take;
  int                    rx_base;
  int                    tx_base;
  int                    tx_next;
  logic [GRP_W-1:0]      wr_grp;
  logic [GRP_W-1:0]      rd_grp;
  bus_wdata_u            wr_word;

  assign last_mot = (mot_q == MOT_W'(NUM_MOTORS - 1));
  assign rx_take  = (state_q == S_RECV) && !frame_n_i && rx_valid_i
                    && (byte_cnt_q < RX_FRAME_BYTES);
  assign tx_next  = int'(byte_cnt_q) + 1;

  // write word for the current step, assembled little-endian
  always_comb begin
    rx_base = int'(mot_q) * RX_BYTES_PER_MOTOR;
    tx_base = int'(mot_q) * TX_BYTES_PER_MOTOR + ((step_q == 2'd0) ? TX_OFS_POS : TX_OFS_PWM);
    rd_grp  = (step_q == 2'd0) ? GRP_POSITION : GRP_PWM;
    wr_word = '0;
    case (step_q)
      2'd0: begin
        wr_grp = GRP_KP;
        wr_word.field.value = {rx_buf[rx_base+RX_OFS_KP+1], rx_buf[rx_base+RX_OFS_KP]};
      end
      2'd1: begin
        wr_grp = GRP_SETPOINT;
        wr_word.setpoint = {rx_buf[rx_base+RX_OFS_SP+3], rx_buf[rx_base+RX_OFS_SP+2],
                            rx_buf[rx_base+RX_OFS_SP+1], rx_buf[rx_base+RX_OFS_SP]};
      end
      default: begin
        wr_grp = GRP_OUT_LIMIT;
        wr_word.field.value = {rx_buf[rx_base+RX_OFS_LIM+1], rx_buf[rx_base+RX_OFS_LIM]};
      end
    endcase
  end

  always_ff @(posedge wCLK24) begin
    if (reset_i) begin
      state_q     <= S_IDLE;
      busy_o      <= 1'b0;
      bus_write_o <= 1'b0;
      bus_read_o  <= 1'b0;
      tx_load_o   <= 1'b0;
      byte_cnt_q  <= '0;
      step_q      <= '0;
      mot_q       <= '0;
      for (int i = 0; i < TX_FRAME_BYTES; i++) begin
        tx_buf[i] <= '0;
      end
    end else begin
      tx_load_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (!frame_n_i) begin
            // first transmit byte goes out as the frame opens
            tx_load_o  <= 1'b1;
            byte_cnt_q <= '0;
            state_q    <= S_RECV;
          end
        end
        S_RECV: begin
          if (frame_n_i) begin
            busy_o  <= 1'b1;
            step_q  <= '0;
            mot_q   <= '0;
            state_q <= S_WRITE;
          end else if (rx_take) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            tx_load_o  <= 1'b1;
          end
        end
        S_WRITE: begin
          bus_write_o <= 1'b1;
          state_q     <= S_WRITE_WAIT;
        end
        S_WRITE_WAIT: begin
          if (!bus_wait_i) begin
            bus_write_o <= 1'b0;
            mot_q       <= mot_q + 1'b1;
            state_q     <= S_WRITE;
            if (last_mot) begin
              step_q <= (step_q == 2'd2) ? 2'd0 : step_q + 2'd1;
              if (step_q == 2'd2) begin
                state_q <= S_READ;
              end
            end
          end
        end
        S_READ: begin
          bus_read_o <= 1'b1;
          state_q    <= S_READ_WAIT;
        end
        default: begin
          if (!bus_wait_i) begin
            bus_read_o          <= 1'b0;
            tx_buf[tx_base]     <= bus_rdata_i[SPI_BYTE_W-1:0];
            tx_buf[tx_base + 1] <= bus_rdata_i[2*SPI_BYTE_W-1:SPI_BYTE_W];
            mot_q               <= mot_q + 1'b1;
            state_q             <= S_READ;
            if (last_mot) begin
              step_q <= (step_q == 2'd1) ? 2'd0 : step_q + 2'd1;
              if (step_q == 2'd1) begin
                busy_o  <= 1'b0;
                state_q <= S_IDLE;
              end
            end
          end
        end
      endcase
    end
  end

  // frame bytes and bus payload
  always_ff @(posedge wCLK24) begin
    if (rx_take) begin
      rx_buf[byte_cnt_q[BYTE_CNT_W-2:0]] <= rx_byte_i;
    end
    if (state_q == S_IDLE) begin
      tx_byte_o <= tx_buf[0];
    end else if (rx_take) begin
      tx_byte_o <= (tx_next < TX_FRAME_BYTES) ? tx_buf[tx_next] : '0;
    end
    if (state_q == S_WRITE) begin
      bus_addr_o  <= {wr_grp, IDX_W'(mot_q)};
      bus_wdata_o <= wr_word;
    end else if (state_q == S_READ) begin
      bus_addr_o  <= {rd_grp, IDX_W'(mot_q)};
    end
  end

endmodule

`default_nettype wire

// File: source/motor_bridge_top.sv
// motor bridge top
`timescale 1ns/1ps
`default_nettype none

module motor_bridge_top (
  input  logic                                   wCLK24,
  input  logic                                   reset_i,
  input  logic                                   frame_n_i,
  input  logic                                   spi_sck_i,
  input  logic                                   spi_mosi_i,
  input  logic signed [motor_bus_pkg::POS_W-1:0] motor_pos_i [motor_bus_pkg::NUM_MOTORS],
  output logic                                   spi_miso_o,
  output logic                                   busy_o,
  output logic signed [motor_bus_pkg::POS_W-1:0] motor_pwm_o [motor_bus_pkg::NUM_MOTORS]
);
  import motor_bus_pkg::*;
  import spi_frame_pkg::*;

  // spi byte stream
  logic                  rx_valid;
  logic [SPI_BYTE_W-1:0] rx_byte;
  logic                  tx_load;
  logic [SPI_BYTE_W-1:0] tx_byte;

  // internal register bus
  logic [BUS_ADDR_W-1:0] bus_addr;
  logic                  bus_write;
  logic                  bus_read;
  bus_wdata_u            bus_wdata;
  logic [BUS_DATA_W-1:0] bus_rdata;
  logic                  bus_wait;

  // decoded strobes
  logic [NUM_MOTORS-1:0] kp_we;
  logic [NUM_MOTORS-1:0] sp_we;
  logic [NUM_MOTORS-1:0] lim_we;
  logic                  addr_bad;

  spi_byte_slave i_spi_byte_slave (
    .wCLK24     (wCLK24),
    .reset_i    (reset_i),
    .frame_n_i  (frame_n_i),
    .spi_sck_i  (spi_sck_i),
    .spi_mosi_i (spi_mosi_i),
    .tx_load_i  (tx_load),
    .tx_byte_i  (tx_byte),
    .spi_miso_o (spi_miso_o),
    .rx_valid_o (rx_valid),
    .rx_byte_o  (rx_byte)
  );

  frame_sequencer i_frame_sequencer (
    .wCLK24      (wCLK24),
    .reset_i     (reset_i),
    .frame_n_i   (frame_n_i),
    .rx_valid_i  (rx_valid),
    .rx_byte_i   (rx_byte),
    .tx_load_o   (tx_load),
    .tx_byte_o   (tx_byte),
    .busy_o      (busy_o),
    .bus_addr_o  (bus_addr),
    .bus_write_o (bus_write),
    .bus_read_o  (bus_read),
    .bus_wdata_o (bus_wdata),
    .bus_wait_i  (bus_wait),
    .bus_rdata_i (bus_rdata)
  );

  reg_decoder i_reg_decoder (
    .bus_addr_i  (bus_addr),
    .bus_write_i (bus_write),
    .kp_we_o     (kp_we),
    .sp_we_o     (sp_we),
    .lim_we_o    (lim_we),
    .addr_bad_o  (addr_bad)
  );

  for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_motor
    motor_channel i_motor_channel (
      .wCLK24   (wCLK24),
      .reset_i  (reset_i),
      .kp_we_i  (kp_we[m]),
      .sp_we_i  (sp_we[m]),
      .lim_we_i (lim_we[m]),
      .wdata_i  (bus_wdata),
      .pos_i    (motor_pos_i[m]),
      .pwm_o    (motor_pwm_o[m])
    );
  end

  readback_mux i_readback_mux (
    .wCLK24      (wCLK24),
    .reset_i     (reset_i),
    .bus_addr_i  (bus_addr),
    .bus_read_i  (bus_read),
    .pos_i       (motor_pos_i),
    .pwm_i       (motor_pwm_o),
    .bus_rdata_o (bus_rdata),
    .bus_wait_o  (bus_wait)
  );

endmodule

`default_nettype wire

// File: source/motor_bus_pkg.sv
// motor bus definitions
`default_nettype none

package motor_bus_pkg;

  // channel count and bus widths
  localparam int NUM_MOTORS = 4;
  localparam int MOT_W      = $clog2(NUM_MOTORS);
  localparam int BUS_ADDR_W = 16;
  localparam int BUS_DATA_W = 32;

  // address split: group in the upper byte, motor index in the lower byte
  localparam int GRP_W = 8;
  localparam int IDX_W = BUS_ADDR_W - GRP_W;

  // register groups
  localparam logic [GRP_W-1:0] GRP_KP        = 8'h00;
  localparam logic [GRP_W-1:0] GRP_SETPOINT  = 8'h03;
  localparam logic [GRP_W-1:0] GRP_OUT_LIMIT = 8'h05;
  localparam logic [GRP_W-1:0] GRP_POSITION  = 8'h0B;
  localparam logic [GRP_W-1:0] GRP_PWM       = 8'h0F;

  // controller widths
  localparam int FIELD_W  = 16;
  localparam int POS_W    = 16;
  localparam int KP_SHIFT = 8;
  // unsigned gain (sign bit added) times a 33-bit error
  localparam int PROD_W   = BUS_DATA_W + FIELD_W + 2;

  // one write word, seen as a setpoint or as a 16-bit gain or limit
  typedef union packed {
    logic signed [BUS_DATA_W-1:0] setpoint;
    struct packed {
      logic [BUS_DATA_W-FIELD_W-1:0] pad;
      logic [FIELD_W-1:0]            value;
    } field;
  } bus_wdata_u;

endpackage

`default_nettype wire

// File: source/motor_channel.sv
// motor channel controller
`timescale 1ns/1ps
`default_nettype none

module motor_channel (
  input  logic                                   wCLK24,
  input  logic                                   reset_i,
  input  logic                                   kp_we_i,
  input  logic                                   sp_we_i,
  input  logic                                   lim_we_i,
  input  motor_bus_pkg::bus_wdata_u              wdata_i,
  input  logic signed [motor_bus_pkg::POS_W-1:0] pos_i,
  output logic signed [motor_bus_pkg::POS_W-1:0] pwm_o
);
  import motor_bus_pkg::*;

  logic        [FIELD_W-1:0]    kp_q;
  logic        [FIELD_W-1:0]    lim_q;
  logic signed [BUS_DATA_W-1:0] sp_q;
  // one extra bit so the error never wraps
  logic signed [BUS_DATA_W:0]   err;
  logic signed [PROD_W-1:0]     prod;
  logic signed [PROD_W-1:0]     prod_sh;
  logic signed [PROD_W-1:0]     lim_pos;
  logic signed [PROD_W-1:0]     lim_neg;
  logic signed [PROD_W-1:0]     ctrl;

  always_comb begin
    err     = sp_q - pos_i;
    prod    = $signed({1'b0, kp_q}) * err;
    prod_sh = prod >>> KP_SHIFT;
    lim_pos = $signed({1'b0, lim_q});
    lim_neg = -lim_pos;
    // symmetric clamp
    if (prod_sh > lim_pos) begin
      ctrl = lim_pos;
    end else if (prod_sh < lim_neg) begin
      ctrl = lim_neg;
    end else begin
      ctrl = prod_sh;
    end
  end

  always_ff @(posedge wCLK24) begin
    if (reset_i) begin
      kp_q  <= '0;
      sp_q  <= '0;
      lim_q <= '0;
      pwm_o <= '0;
    end else begin
      if (kp_we_i) begin
        kp_q <= wdata_i.field.value;
      end
      if (sp_we_i) begin
        sp_q <= wdata_i.setpoint;
      end
      if (lim_we_i) begin
        lim_q <= wdata_i.field.value;
      end
      pwm_o <= ctrl[POS_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: source/readback_mux.sv
// status readback mux
`timescale 1ns/1ps
`default_nettype none

module readback_mux (
  input  logic                                   wCLK24,
  input  logic                                   reset_i,
  input  logic [motor_bus_pkg::BUS_ADDR_W-1:0]   bus_addr_i,
  input  logic                                   bus_read_i,
  input  logic signed [motor_bus_pkg::POS_W-1:0] pos_i [motor_bus_pkg::NUM_MOTORS],
  input  logic signed [motor_bus_pkg::POS_W-1:0] pwm_i [motor_bus_pkg::NUM_MOTORS],
  output logic [motor_bus_pkg::BUS_DATA_W-1:0]   bus_rdata_o,
  output logic                                   bus_wait_o
);
  import motor_bus_pkg::*;

  logic                    rd_pend_q;
  logic [GRP_W-1:0]        grp;
  logic [IDX_W-1:0]        idx;
  logic signed [POS_W-1:0] sel;

  assign grp = bus_addr_i[BUS_ADDR_W-1 -: GRP_W];
  assign idx = bus_addr_i[IDX_W-1:0];
  // first read cycle always stalls
  assign bus_wait_o = bus_read_i & ~rd_pend_q;

  always_comb begin
    sel = '0;
    if (idx < NUM_MOTORS) begin
      case (grp)
        GRP_POSITION: sel = pos_i[idx[MOT_W-1:0]];
        GRP_PWM:      sel = pwm_i[idx[MOT_W-1:0]];
        default:      sel = '0;
      endcase
    end
  end

  always_ff @(posedge wCLK24) begin
    if (reset_i) begin
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= bus_wait_o;
    end
  end

  always_ff @(posedge wCLK24) begin
    if (bus_wait_o) begin
      bus_rdata_o <= {{(BUS_DATA_W-POS_W){sel[POS_W-1]}}, sel};
    end
  end

endmodule

`default_nettype wire

// File: source/reg_decoder.sv
// register address decoder
`timescale 1ns/1ps
`default_nettype none

module reg_decoder (
  input  logic [motor_bus_pkg::BUS_ADDR_W-1:0] bus_addr_i,
  input  logic                                 bus_write_i,
  output logic [motor_bus_pkg::NUM_MOTORS-1:0] kp_we_o,
  output logic [motor_bus_pkg::NUM_MOTORS-1:0] sp_we_o,
  output logic [motor_bus_pkg::NUM_MOTORS-1:0] lim_we_o,
  output logic                                 addr_bad_o
);
  import motor_bus_pkg::*;

  logic [GRP_W-1:0] grp;
  logic [IDX_W-1:0] idx;
  logic             grp_ok;

  assign grp = bus_addr_i[BUS_ADDR_W-1 -: GRP_W];
  assign idx = bus_addr_i[IDX_W-1:0];

  always_comb begin
    grp_ok = grp inside {GRP_KP, GRP_SETPOINT, GRP_OUT_LIMIT, GRP_POSITION, GRP_PWM};
    addr_bad_o = !grp_ok || (idx >= NUM_MOTORS);
    // one strobe per channel and group
    for (int m = 0; m < NUM_MOTORS; m++) begin
      kp_we_o[m]  = bus_write_i && (idx == IDX_W'(m)) && (grp == GRP_KP);
      sp_we_o[m]  = bus_write_i && (idx == IDX_W'(m)) && (grp == GRP_SETPOINT);
      lim_we_o[m] = bus_write_i && (idx == IDX_W'(m)) && (grp == GRP_OUT_LIMIT);
    end
  end

endmodule

`default_nettype wire

// File: source/spi_byte_slave.sv
// spi byte slave
`timescale 1ns/1ps
`default_nettype none

module spi_byte_slave (
  input  logic                                 wCLK24,
  input  logic                                 reset_i,
  input  logic                                 frame_n_i,
  input  logic                                 spi_sck_i,
  input  logic                                 spi_mosi_i,
  input  logic                                 tx_load_i,
  input  logic [spi_frame_pkg::SPI_BYTE_W-1:0] tx_byte_i,
  output logic                                 spi_miso_o,
  output logic                                 rx_valid_o,
  output logic [spi_frame_pkg::SPI_BYTE_W-1:0] rx_byte_o
);
  import spi_frame_pkg::*;

  // two sync stages plus one for edge detect
  logic [2:0]                      sck_sync_q;
  logic [1:0]                      mosi_sync_q;
  logic [$clog2(SPI_BYTE_W)-1:0]   bit_cnt_q;
  logic [SPI_BYTE_W-1:0]           rx_shift_q;
  logic [SPI_BYTE_W-1:0]           tx_shift_q;
  logic                            sck_rise;
  logic                            sck_fall;
  logic                            last_bit;

  assign sck_rise   = sck_sync_q[1] & ~sck_sync_q[2] & ~frame_n_i;
  assign sck_fall   = ~sck_sync_q[1] & sck_sync_q[2] & ~frame_n_i;
  assign last_bit   = (bit_cnt_q == SPI_BYTE_W - 1);
  assign spi_miso_o = tx_shift_q[SPI_BYTE_W-1];

  always_ff @(posedge wCLK24) begin
    if (reset_i) begin
      sck_sync_q <= '0;
      bit_cnt_q  <= '0;
      rx_valid_o <= 1'b0;
      tx_shift_q <= '0;
    end else begin
      sck_sync_q <= {sck_sync_q[1:0], spi_sck_i};
      rx_valid_o <= sck_rise & last_bit;
      if (frame_n_i) begin
        bit_cnt_q <= '0;
      end else if (sck_rise) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      // at a byte boundary the freshly loaded MSB must stay on the line
      if (tx_load_i) begin
        tx_shift_q <= tx_byte_i;
      end else if (sck_fall && bit_cnt_q != '0) begin
        tx_shift_q <= {tx_shift_q[SPI_BYTE_W-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge wCLK24) begin
    mosi_sync_q <= {mosi_sync_q[0], spi_mosi_i};
    if (sck_rise) begin
      rx_shift_q <= {rx_shift_q[SPI_BYTE_W-2:0], mosi_sync_q[1]};
      if (last_bit) begin
        rx_byte_o <= {rx_shift_q[SPI_BYTE_W-2:0], mosi_sync_q[1]};
      end
    end
  end

endmodule

`default_nettype wire

// File: source/spi_frame_pkg.sv
// spi frame layout
`default_nettype none

package spi_frame_pkg;

  localparam int SPI_BYTE_W = 8;

  // receive frame, per motor: gain, setpoint, limit
  localparam int RX_BYTES_PER_MOTOR = 8;
  localparam int RX_FRAME_BYTES     = 32;
  localparam int RX_OFS_KP          = 0;
  localparam int RX_OFS_SP          = 2;
  localparam int RX_OFS_LIM         = 6;

  // transmit frame, per motor: position, pwm
  localparam int TX_BYTES_PER_MOTOR = 4;
  localparam int TX_FRAME_BYTES     = 16;
  localparam int TX_OFS_POS         = 0;
  localparam int TX_OFS_PWM         = 2;

  // byte counter saturates at RX_FRAME_BYTES
  localparam int BYTE_CNT_W = $clog2(RX_FRAME_BYTES) + 1;

endpackage

`default_nettype wire
